// File: build.f
+incdir+testbench
logic/eth_loop_pkg.sv
logic/eth_frame_loop_csum.sv
logic/frame_fifo.sv
logic/csum_patch_counter.sv
logic/loop_tx_fsm.sv
logic/eth_frame_loop.sv
testbench/eth_frame_loop_asserts.sv
testbench/eth_frame_loop_tb.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the loopback testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f build.f \
	--top-module eth_frame_loop_tb -o eth_frame_loop_sim
./obj_dir/eth_frame_loop_sim | tee sim.log

if grep -q "Finished with no errors" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// File: testbench/eth_frame_tasks.svh
// frame builders and the reference layer-4 checksum, included inside the loopback testbench module
logic [7:0] frm[$];
int csum_hi_idx;
logic [15:0] csum_val;

function automatic logic [15:0] fold_sum(input logic [31:0] sum);
	logic [31:0] s;
	s = sum;
	while (s[31:16] != 16'd0) begin
		s = {16'd0, s[15:0]} + {16'd0, s[31:16]};
	end
	return s[15:0];
endfunction

// segment words plus pseudo-header, checksum field counted as zero
function automatic logic [15:0] ref_csum(input int l4_start, input int l4_len,
	input int csum_off, input logic [31:0] pseudo);
	logic [31:0] sum;
	logic [7:0] hi;
	logic [7:0] lo;
	logic [15:0] res;
	int i;
	sum = pseudo;
	for (i = 0; i < l4_len; i += 2) begin
		hi = frm[l4_start + i];
		lo = (i + 1 < l4_len) ? frm[l4_start + i + 1] : 8'h00;
		if (i == csum_off) begin
			hi = 8'h00;
			lo = 8'h00;
		end
		sum = sum + {16'd0, hi, lo};
	end
	res = ~fold_sum(sum);
	return (res == 16'h0000) ? 16'hFFFF : res;
endfunction

task start_frame(input logic [15:0] ethertype);
	frm.delete();
	csum_hi_idx = -1;
	csum_val = 16'h0000;
	frm.push_back(8'h02);
	repeat (4) frm.push_back(8'h00);
	frm.push_back(8'h01);
	frm.push_back(8'h02);
	repeat (4) frm.push_back(8'h00);
	frm.push_back(8'h02);
	frm.push_back(ethertype[15:8]);
	frm.push_back(ethertype[7:0]);
endtask

// field bytes hold junk so the engine has to skip them
task add_segment(input int len, input int csum_off);
	int i;
	for (i = 0; i < len; i++) begin
		if (csum_off >= 0 && (i == csum_off || i == csum_off + 1)) begin
			frm.push_back(8'hA5);
		end else begin
			frm.push_back(8'(i * 7 + 3));
		end
	end
endtask

task build_ipv4(input logic [7:0] proto, input int opt_words, input int l4_len,
	input int csum_off, input int pad_len);
	int ihl;
	int total;
	int l4_start;
	int i;
	logic [31:0] pseudo;
	ihl = 5 + opt_words;
	total = ihl * 4 + l4_len;
	start_frame(16'h0800);
	frm.push_back(8'(8'h40 + ihl));
	frm.push_back(8'h00);
	frm.push_back(8'(total >> 8));
	frm.push_back(8'(total));
	frm.push_back(8'h12);
	frm.push_back(8'h34);
	frm.push_back(8'h40);
	frm.push_back(8'h00);
	frm.push_back(8'h40);
	frm.push_back(proto);
	frm.push_back(8'h00);
	frm.push_back(8'h00);
	for (i = 0; i < 8; i++) begin
		frm.push_back(8'(8'hC0 + i * 29));
	end
	// NOP options
	repeat (opt_words * 4) frm.push_back(8'h01);
	l4_start = frm.size();
	add_segment(l4_len, csum_off);
	repeat (pad_len) frm.push_back(8'hEE);
	if (csum_off >= 0) begin
		pseudo = {24'd0, proto} + 32'(l4_len);
		for (i = 26; i < 34; i += 2) begin
			pseudo = pseudo + {16'd0, frm[i], frm[i + 1]};
		end
		csum_val = ref_csum(l4_start, l4_len, csum_off, pseudo);
		csum_hi_idx = l4_start + csum_off;
	end
endtask

task build_ipv6(input logic [7:0] next_hdr, input int l4_len, input int csum_off);
	int i;
	logic [31:0] pseudo;
	start_frame(16'h86DD);
	frm.push_back(8'h60);
	repeat (3) frm.push_back(8'h00);
	frm.push_back(8'(l4_len >> 8));
	frm.push_back(8'(l4_len));
	frm.push_back(next_hdr);
	frm.push_back(8'h40);
	for (i = 0; i < 32; i++) begin
		frm.push_back(8'(8'h20 + i * 11));
	end
	add_segment(l4_len, csum_off);
	pseudo = {24'd0, next_hdr} + 32'(l4_len);
	for (i = 22; i < 54; i += 2) begin
		pseudo = pseudo + {16'd0, frm[i], frm[i + 1]};
	end
	csum_val = ref_csum(54, l4_len, csum_off, pseudo);
	csum_hi_idx = 54 + csum_off;
endtask

// File: testbench/eth_frame_loop_tb.sv
// directed testbench for the loopback block, run through build.f and run.sh
module eth_frame_loop_tb;
	import eth_loop_pkg::*;

	localparam int DRV = 2;
	localparam int WAIT_LIMIT = 6000;

	logic clk;
	logic rst_n;
	byte_t s_data;
	rx_flags_t s_user;
	logic s_last;
	logic s_valid;
	byte_t m_data;
	logic m_last;
	logic m_valid;
	logic m_ready;

	logic rand_ready;
	integer seed = 48806;
	int errors;
	int checks;
	logic [7:0] exp_bytes[$];
	int exp_lens[$];
	logic [7:0] got_bytes[$];
	int got_lens[$];

	`include "eth_frame_tasks.svh"

	eth_frame_loop #(
		.DATA_DEPTH_LOG2(11),
		.DESC_DEPTH_LOG2(3)
	) DUT (
		.clk(clk),
		.rst_n(rst_n),
		.s_data(s_data),
		.s_user(s_user),
		.s_last(s_last),
		.s_valid(s_valid),
		.m_data(m_data),
		.m_last(m_last),
		.m_valid(m_valid),
		.m_ready(m_ready)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		m_ready = 1'b1;
		forever begin
			@(posedge clk);
			#DRV;
			m_ready = rand_ready ? 1'($random(seed)) : 1'b1;
		end
	end

	// sampled mid-cycle where the handshake is settled
	initial begin
		int len;
		len = 0;
		forever begin
			@(negedge clk);
			if (rst_n && m_valid && m_ready) begin
				got_bytes.push_back(m_data);
				len++;
				if (m_last) begin
					got_lens.push_back(len);
					len = 0;
				end
			end
		end
	end

	task check_value(input string what, input logic [31:0] expected, input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("ERR %s expected %0h actual %0h", what, expected, actual);
		end
	endtask

	task send_frame(input rx_flags_t flags, input logic keep);
		int i;
		if (keep) begin
			for (i = 0; i < frm.size(); i++) begin
				if (csum_hi_idx >= 0 && i == csum_hi_idx) begin
					exp_bytes.push_back(csum_val[15:8]);
				end else if (csum_hi_idx >= 0 && i == csum_hi_idx + 1) begin
					exp_bytes.push_back(csum_val[7:0]);
				end else begin
					exp_bytes.push_back(frm[i]);
				end
			end
			exp_lens.push_back(frm.size());
		end
		for (i = 0; i < frm.size(); i++) begin
			s_data = frm[i];
			s_user = flags;
			s_last = (i == frm.size() - 1);
			s_valid = 1'b1;
			@(posedge clk);
			#DRV;
		end
		s_valid = 1'b0;
		s_last = 1'b0;
		s_user = 2'b00;
	endtask

	// waits for every expected frame, then a short quiet spell for stray output
	task compare_frames(input string name);
		int cycles;
		int i;
		int n;
		cycles = 0;
		while (got_lens.size() < exp_lens.size() && cycles < WAIT_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		if (got_lens.size() < exp_lens.size()) begin
			errors++;
			$display("%s: timed out waiting for output frames", name);
		end
		repeat (60) @(posedge clk);
		#DRV;
		check_value({name, " frame count"}, exp_lens.size(), got_lens.size());
		n = (exp_lens.size() < got_lens.size()) ? exp_lens.size() : got_lens.size();
		for (i = 0; i < n; i++) begin
			check_value($sformatf("%s frame %0d length", name, i), exp_lens[i], got_lens[i]);
		end
		n = (exp_bytes.size() < got_bytes.size()) ? exp_bytes.size() : got_bytes.size();
		for (i = 0; i < n; i++) begin
			check_value($sformatf("%s byte %0d", name, i), exp_bytes[i], got_bytes[i]);
		end
		exp_bytes.delete();
		exp_lens.delete();
		got_bytes.delete();
		got_lens.delete();
	endtask

	task test_ipv4_udp();
		build_ipv4(8'h11, 0, 21, 6, 0);
		send_frame(2'b00, 1'b1);
		compare_frames("ipv4_udp");
	endtask

	task test_ipv4_tcp_options();
		build_ipv4(8'h06, 2, 27, 16, 7);
		send_frame(2'b00, 1'b1);
		compare_frames("ipv4_tcp_opts");
	endtask

	task test_ipv6();
		build_ipv6(8'h11, 19, 6);
		send_frame(2'b00, 1'b1);
		build_ipv6(8'h3A, 16, 2);
		send_frame(2'b00, 1'b1);
		compare_frames("ipv6");
	endtask

	task test_passthrough();
		start_frame(16'h88B5);
		add_segment(46, -1);
		send_frame(2'b00, 1'b1);
		build_ipv4(8'h2F, 0, 24, -1, 0);
		send_frame(2'b00, 1'b1);
		compare_frames("passthrough");
	endtask

	task test_flagged_drop();
		build_ipv4(8'h11, 0, 30, 6, 0);
		send_frame(2'b00, 1'b1);
		build_ipv4(8'h06, 0, 40, 16, 0);
		send_frame(2'b01, 1'b0);
		build_ipv4(8'h06, 1, 33, 16, 0);
		send_frame(2'b00, 1'b1);
		build_ipv6(8'h11, 12, 6);
		send_frame(2'b10, 1'b0);
		build_ipv6(8'h3A, 25, 2);
		send_frame(2'b00, 1'b1);
		compare_frames("flagged_drop");
	endtask

	task test_backpressure();
		rand_ready = 1'b1;
		build_ipv4(8'h11, 0, 45, 6, 0);
		send_frame(2'b00, 1'b1);
		build_ipv6(8'h11, 31, 6);
		send_frame(2'b00, 1'b1);
		build_ipv4(8'h06, 3, 22, 16, 5);
		send_frame(2'b00, 1'b1);
		start_frame(16'h0806);
		add_segment(50, -1);
		send_frame(2'b00, 1'b1);
		build_ipv6(8'h3A, 40, 2);
		send_frame(2'b00, 1'b1);
		compare_frames("backpressure");
		rand_ready = 1'b0;
	endtask

	initial begin
		errors = 0;
		checks = 0;
		rand_ready = 1'b0;
		rst_n = 1'b0;
		s_data = 8'h00;
		s_user = 2'b00;
		s_last = 1'b0;
		s_valid = 1'b0;
		repeat (5) @(posedge clk);
		#DRV;
		rst_n = 1'b1;
		@(posedge clk);
		#DRV;
		test_ipv4_udp();
		test_ipv4_tcp_options();
		test_ipv6();
		test_passthrough();
		test_flagged_drop();
		test_backpressure();
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// File: testbench/eth_frame_loop_asserts.sv
// output handshake and reset checks, bound into every transmit FSM instance
module eth_frame_loop_asserts (
	input logic clk,
	input logic rst_n,
	input eth_loop_pkg::byte_t m_data,
	input logic m_last,
	input logic m_valid,
	input logic m_ready
);

	// an offered byte holds until it is taken
	property stall_holds;
		@(posedge clk) disable iff (!rst_n)
		(m_valid && !m_ready) |=> (m_valid && $stable(m_data) && $stable(m_last));
	endproperty

	property idle_after_reset;
		@(posedge clk) !rst_n |=> !m_valid;
	endproperty

	stall_check: assert property (stall_holds)
		else $error("output byte changed while the sink stalled");

	reset_check: assert property (idle_after_reset)
		else $error("m_valid high right after reset");

endmodule

bind loop_tx_fsm eth_frame_loop_asserts u_asserts (
	.clk(clk),
	.rst_n(rst_n),
	.m_data(m_data),
	.m_last(m_last),
	.m_valid(m_valid),
	.m_ready(m_ready)
);

// File: logic/eth_frame_loop.sv
// loopback top level with checksum offload between the receive and transmit streams
module eth_frame_loop #(
	parameter int DATA_DEPTH_LOG2 = 11,
	parameter int DESC_DEPTH_LOG2 = 3
) (
	input logic clk,
	input logic rst_n,

	input eth_loop_pkg::byte_t s_data,
	input eth_loop_pkg::rx_flags_t s_user,
	input logic s_last,
	input logic s_valid,

	output eth_loop_pkg::byte_t m_data,
	output logic m_last,
	output logic m_valid,
	input logic m_ready
);
	import eth_loop_pkg::*;

	byte_t csum_data;
	rx_flags_t csum_flags;
	logic csum_last;
	logic csum_valid;
	csum_t csum_value;
	csum_pos_t csum_pos;

	byte_t rd_data;
	logic rd_last;
	logic rd_en;
	logic frame_avail;
	logic desc_pop;
	csum_t desc_value;
	csum_pos_t desc_pos;

	logic pos_clear;
	logic pos_step;
	logic at_csum_hi;
	logic at_csum_lo;

	eth_frame_loop_csum u_csum (
		.clk(clk),
		.rst_n(rst_n),
		.s_data(s_data),
		.s_user(s_user),
		.s_last(s_last),
		.s_valid(s_valid),
		.csum_data(csum_data),
		.csum_flags(csum_flags),
		.csum_last(csum_last),
		.csum_valid(csum_valid),
		.csum_value(csum_value),
		.csum_pos(csum_pos)
	);

	frame_fifo #(
		.DATA_DEPTH_LOG2(DATA_DEPTH_LOG2),
		.DESC_DEPTH_LOG2(DESC_DEPTH_LOG2)
	) u_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.csum_data(csum_data),
		.csum_flags(csum_flags),
		.csum_last(csum_last),
		.csum_valid(csum_valid),
		.csum_value(csum_value),
		.csum_pos(csum_pos),
		.rd_en(rd_en),
		.desc_pop(desc_pop),
		.rd_data(rd_data),
		.rd_last(rd_last),
		.frame_avail(frame_avail),
		.desc_value(desc_value),
		.desc_pos(desc_pos)
	);

	// counter sees the descriptor position straight from the buffer
	csum_patch_counter u_counter (
		.clk(clk),
		.rst_n(rst_n),
		.pos_clear(pos_clear),
		.pos_step(pos_step),
		.desc_pos(desc_pos),
		.at_csum_hi(at_csum_hi),
		.at_csum_lo(at_csum_lo)
	);

	loop_tx_fsm u_tx (
		.clk(clk),
		.rst_n(rst_n),
		.frame_avail(frame_avail),
		.desc_value(desc_value),
		.rd_data(rd_data),
		.rd_last(rd_last),
		.at_csum_hi(at_csum_hi),
		.at_csum_lo(at_csum_lo),
		.rd_en(rd_en),
		.desc_pop(desc_pop),
		.pos_clear(pos_clear),
		.pos_step(pos_step),
		.m_data(m_data),
		.m_last(m_last),
		.m_valid(m_valid),
		.m_ready(m_ready)
	);

endmodule

// File: logic/loop_tx_fsm.sv
// transmit FSM that replays buffered frames on the output stream and patches in the checksum
module loop_tx_fsm (
	input logic clk,
	input logic rst_n,

	input logic frame_avail,
	input eth_loop_pkg::csum_t desc_value,
	input eth_loop_pkg::byte_t rd_data,
	input logic rd_last,
	input logic at_csum_hi,
	input logic at_csum_lo,

	output logic rd_en,
	output logic desc_pop,
	output logic pos_clear,
	output logic pos_step,

	output eth_loop_pkg::byte_t m_data,
	output logic m_last,
	output logic m_valid,
	input logic m_ready
);
	import eth_loop_pkg::*;

	typedef enum logic [1:0] {TX_IDLE, TX_LOAD, TX_SEND, TX_FINISH} tx_state_t;

	tx_state_t state;
	tx_state_t state_next;
	logic load;
	byte_t patch_byte;

	always_comb begin
		state_next = state;
		rd_en = 1'b0;
		desc_pop = 1'b0;
		pos_clear = 1'b0;
		pos_step = 1'b0;
		load = 1'b0;

		case (state)
			TX_IDLE: begin
				if (frame_avail) begin
					rd_en = 1'b1;
					pos_clear = 1'b1;
					state_next = TX_LOAD;
				end
			end
			TX_LOAD: begin
				// first byte, prefetch the second
				load = 1'b1;
				pos_step = 1'b1;
				rd_en = !rd_last;
				state_next = TX_SEND;
			end
			TX_SEND: begin
				if (m_ready) begin
					if (m_last) begin
						state_next = TX_FINISH;
					end else begin
						load = 1'b1;
						pos_step = 1'b1;
						rd_en = !rd_last;
					end
				end
			end
			TX_FINISH: begin
				desc_pop = 1'b1;
				state_next = TX_IDLE;
			end
			default: begin
				state_next = TX_IDLE;
			end
		endcase
	end

	// zero value means nothing to patch
	always_comb begin
		patch_byte = rd_data;
		if (desc_value != '0) begin
			if (at_csum_hi) begin
				patch_byte = desc_value[15:8];
			end else if (at_csum_lo) begin
				patch_byte = desc_value[7:0];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= TX_IDLE;
			m_valid <= 1'b0;
		end else begin
			state <= state_next;
			if (load) begin
				m_valid <= 1'b1;
			end else if (m_ready) begin
				m_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			m_data <= patch_byte;
			m_last <= rd_last;
		end
	end

endmodule

// File: logic/csum_patch_counter.sv
// byte index of the frame being sent, flagging where the checksum bytes go
module csum_patch_counter (
	input logic clk,
	input logic rst_n,

	input logic pos_clear,
	input logic pos_step,
	input eth_loop_pkg::csum_pos_t desc_pos,

	output logic at_csum_hi,
	output logic at_csum_lo
);
	import eth_loop_pkg::*;

	// index of the byte now offered by the buffer
	frame_pos_t pos;
	frame_pos_t lo_pos;

	always_ff @(posedge clk) begin
		if (!rst_n || pos_clear) begin
			pos <= '0;
		end else if (pos_step) begin
			pos <= pos + 1'b1;
		end
	end

	always_comb begin
		lo_pos = {1'b0, desc_pos};
		at_csum_lo = pos == lo_pos;
		// high byte sits just before the low one
		at_csum_hi = pos == lo_pos - 1'b1;
	end

endmodule

// File: logic/frame_fifo.sv
// frame buffer with per-frame commit or rollback and a checksum descriptor queue for the transmitter
module frame_fifo #(
	parameter int DATA_DEPTH_LOG2 = 11,
	parameter int DESC_DEPTH_LOG2 = 3
) (
	input logic clk,
	input logic rst_n,

	input eth_loop_pkg::byte_t csum_data,
	input eth_loop_pkg::rx_flags_t csum_flags,
	input logic csum_last,
	input logic csum_valid,
	input eth_loop_pkg::csum_t csum_value,
	input eth_loop_pkg::csum_pos_t csum_pos,

	input logic rd_en,
	input logic desc_pop,
	output eth_loop_pkg::byte_t rd_data,
	output logic rd_last,
	output logic frame_avail,
	output eth_loop_pkg::csum_t desc_value,
	output eth_loop_pkg::csum_pos_t desc_pos
);
	import eth_loop_pkg::*;

	localparam int DATA_DEPTH = 1 << DATA_DEPTH_LOG2;
	localparam int DESC_DEPTH = 1 << DESC_DEPTH_LOG2;

	// byte plus its last flag
	logic [8:0] data_mem [DATA_DEPTH];
	csum_t desc_val_mem [DESC_DEPTH];
	csum_pos_t desc_pos_mem [DESC_DEPTH];

	logic [DATA_DEPTH_LOG2:0] wr_ptr;
	logic [DATA_DEPTH_LOG2:0] wr_commit;
	logic [DATA_DEPTH_LOG2:0] rd_ptr;
	logic [DATA_DEPTH_LOG2:0] wr_fill;
	logic [DESC_DEPTH_LOG2:0] dwr_ptr;
	logic [DESC_DEPTH_LOG2:0] drd_ptr;
	logic [DESC_DEPTH_LOG2:0] desc_fill;
	logic data_full;
	logic desc_full;
	logic wr_en;
	logic ovf;
	logic frame_ok;
	logic push;

	always_comb begin
		wr_fill = wr_ptr - rd_ptr;
		data_full = wr_fill[DATA_DEPTH_LOG2];
		desc_fill = dwr_ptr - drd_ptr;
		desc_full = desc_fill[DESC_DEPTH_LOG2];
		// nothing more is stored once the frame has overflowed
		wr_en = csum_valid && !data_full && !ovf;
		frame_ok = !ovf && !data_full && !desc_full &&
			!csum_flags[FLAG_DROP] && !csum_flags[FLAG_FCS_BAD];
		push = csum_valid && csum_last && frame_ok;
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			data_mem[wr_ptr[DATA_DEPTH_LOG2-1:0]] <= {csum_last, csum_data};
		end
		if (rd_en) begin
			{rd_last, rd_data} <= data_mem[rd_ptr[DATA_DEPTH_LOG2-1:0]];
		end
		if (push) begin
			desc_val_mem[dwr_ptr[DESC_DEPTH_LOG2-1:0]] <= csum_value;
			desc_pos_mem[dwr_ptr[DESC_DEPTH_LOG2-1:0]] <= csum_pos;
		end
	end

	// speculative write side, committed or rolled back on the last beat
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			wr_commit <= '0;
			ovf <= 1'b0;
		end else if (csum_valid) begin
			if (csum_last) begin
				if (frame_ok) begin
					wr_ptr <= wr_ptr + 1'b1;
					wr_commit <= wr_ptr + 1'b1;
				end else begin
					wr_ptr <= wr_commit;
				end
				ovf <= 1'b0;
			end else begin
				if (wr_en) begin
					wr_ptr <= wr_ptr + 1'b1;
				end
				if (data_full) begin
					ovf <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_ptr <= '0;
			dwr_ptr <= '0;
			drd_ptr <= '0;
		end else begin
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (push) begin
				dwr_ptr <= dwr_ptr + 1'b1;
			end
			if (desc_pop) begin
				drd_ptr <= drd_ptr + 1'b1;
			end
		end
	end

	assign frame_avail = dwr_ptr != drd_ptr;
	assign desc_value = desc_val_mem[drd_ptr[DESC_DEPTH_LOG2-1:0]];
	assign desc_pos = desc_pos_mem[drd_ptr[DESC_DEPTH_LOG2-1:0]];

endmodule

// File: logic/eth_frame_loop_csum.sv
// header parser and layer-4 checksum engine that tags each frame for the loopback buffer
module eth_frame_loop_csum (
	input logic clk,
	input logic rst_n,

	input eth_loop_pkg::byte_t s_data,
	input eth_loop_pkg::rx_flags_t s_user,
	input logic s_last,
	input logic s_valid,

	output eth_loop_pkg::byte_t csum_data,
	output eth_loop_pkg::rx_flags_t csum_flags,
	output logic csum_last,
	output logic csum_valid,
	output eth_loop_pkg::csum_t csum_value,
	output eth_loop_pkg::csum_pos_t csum_pos
);
	import eth_loop_pkg::*;

	typedef enum logic [1:0] {ETH_UNKNOWN, ETH_IPV4, ETH_IPV6} eth_proto_t;

	localparam byte_t PROTO_ICMP = 8'h01;
	localparam byte_t PROTO_TCP = 8'h06;
	localparam byte_t PROTO_UDP = 8'h11;
	localparam byte_t PROTO_ICMPV6 = 8'h3A;

	eth_proto_t proto;
	frame_pos_t count;
	frame_pos_t l4_start;
	frame_pos_t data_end;
	frame_pos_t pos_lo;
	logic l4_ok;
	logic icmp4;
	byte_t prev_byte;
	csum_t acc;
	csum_t acc_next;
	csum_t add_word;
	csum_t final_sum;
	logic [16:0] sum_wide;
	logic in_data;
	logic zero_byte;

	always_comb begin
		in_data = l4_ok && count >= l4_start && count <= data_end;
		add_word = '0;

		case (proto)
			ETH_IPV4: begin
				// seed with minus the header length so adding total length gives L4 length
				if (count == 16'd14) begin
					add_word = ~{10'd0, s_data[3:0], 2'b00};
				end else if (count == 16'd17) begin
					add_word = {prev_byte, s_data};
				end else if (count == 16'd23) begin
					add_word = {8'h00, s_data};
				end else if (count >= 16'd27 && count <= 16'd33 && count[0] && !icmp4) begin
					add_word = {prev_byte, s_data};
				end
			end
			ETH_IPV6: begin
				if (count == 16'd19) begin
					add_word = {prev_byte, s_data};
				end else if (count == 16'd20) begin
					add_word = {8'h00, s_data};
				end else if (count >= 16'd23 && count <= 16'd53 && count[0]) begin
					add_word = {prev_byte, s_data};
				end
			end
			default: begin
				add_word = '0;
			end
		endcase

		// payload words, checksum field skipped
		if (in_data) begin
			if (count[0] && count != pos_lo) begin
				add_word = {prev_byte, s_data};
			end else if (!count[0] && count == data_end) begin
				// odd tail padded with a zero low byte
				add_word = {s_data, 8'h00};
			end
		end

		sum_wide = {1'b0, acc} + {1'b0, add_word};
		acc_next = sum_wide[15:0] + {15'd0, sum_wide[16]};

		// all-zero result is sent as all-ones
		final_sum = (acc_next == 16'hFFFF) ? 16'hFFFF : ~acc_next;

		zero_byte = l4_ok && (count == pos_lo || count == pos_lo - 16'd1);
	end

	// parser state starts over on the beat after each frame end
	always_ff @(posedge clk) begin
		if (!rst_n || (s_valid && s_last)) begin
			proto <= ETH_UNKNOWN;
			count <= '0;
			acc <= '0;
			l4_ok <= 1'b0;
			icmp4 <= 1'b0;
			l4_start <= '0;
			data_end <= '0;
			pos_lo <= '0;
		end else if (s_valid) begin
			count <= count + 16'd1;
			acc <= acc_next;

			if (count == 16'd13) begin
				if ({prev_byte, s_data} == 16'h0800) begin
					proto <= ETH_IPV4;
				end else if ({prev_byte, s_data} == 16'h86DD) begin
					proto <= ETH_IPV6;
					l4_start <= 16'd54;
				end
			end

			case (proto)
				ETH_IPV4: begin
					if (count == 16'd14) begin
						l4_start <= {10'd0, s_data[3:0], 2'b00} + 16'd14;
					end
					if (count == 16'd17) begin
						data_end <= {prev_byte, s_data} + 16'd13;
					end
					if (count == 16'd23) begin
						if (s_data == PROTO_TCP) begin
							pos_lo <= l4_start + 16'd17;
							l4_ok <= 1'b1;
						end else if (s_data == PROTO_UDP) begin
							pos_lo <= l4_start + 16'd7;
							l4_ok <= 1'b1;
						end else if (s_data == PROTO_ICMP) begin
							// plain ICMP has no pseudo-header
							pos_lo <= l4_start + 16'd3;
							l4_ok <= 1'b1;
							icmp4 <= 1'b1;
							acc <= '0;
						end
					end
				end
				ETH_IPV6: begin
					if (count == 16'd19) begin
						data_end <= {prev_byte, s_data} + 16'd53;
					end
					if (count == 16'd20) begin
						if (s_data == PROTO_TCP) begin
							pos_lo <= 16'd71;
							l4_ok <= 1'b1;
						end else if (s_data == PROTO_UDP) begin
							pos_lo <= 16'd61;
							l4_ok <= 1'b1;
						end else if (s_data == PROTO_ICMPV6) begin
							pos_lo <= 16'd57;
							l4_ok <= 1'b1;
						end
					end
				end
				default: begin
					l4_ok <= 1'b0;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			csum_valid <= 1'b0;
		end else begin
			csum_valid <= s_valid;
		end
	end

	// one-cycle delayed byte with the tag loaded on the last beat
	always_ff @(posedge clk) begin
		if (s_valid) begin
			prev_byte <= s_data;
			csum_data <= zero_byte ? 8'h00 : s_data;
			csum_last <= s_last;
			csum_flags <= s_user;
			if (s_last) begin
				csum_value <= l4_ok ? final_sum : 16'h0000;
				csum_pos <= l4_ok ? pos_lo[14:0] : 15'd0;
			end
		end
	end

endmodule

// File: logic/eth_loop_pkg.sv
// shared widths, stream types and flag bit positions imported by every loopback module
package eth_loop_pkg;

	localparam int BYTE_W = 8;
	localparam int POS_W = 16;
	localparam int CSUM_W = 16;
	localparam int FLAGS_W = 2;

	// one byte of the frame stream
	typedef logic [BYTE_W-1:0] byte_t;

	// byte index inside a frame
	typedef logic [POS_W-1:0] frame_pos_t;

	// one's-complement checksum value
	typedef logic [CSUM_W-1:0] csum_t;

	// per-frame receive flags
	typedef logic [FLAGS_W-1:0] rx_flags_t;

	// checksum position as carried in the frame tag
	typedef logic [POS_W-2:0] csum_pos_t;

	// flag bits inside rx_flags_t
	localparam int FLAG_DROP = 1;
	localparam int FLAG_FCS_BAD = 0;

endpackage
